// File: game_pkg.sv
package game_pkg;

    // SDRAM side widths
    typedef logic [21:0] sdram_addr_t;
    typedef logic [15:0] word_t;
    typedef logic [ 1:0] bank_t;

    // Byte address from the ROM download
    typedef logic [24:0] ioctl_addr_t;

    // Download regions, in bytes
    // Bytes below BA1_START go to bank 0, then bank 1 up to BA2_START
    localparam ioctl_addr_t BA1_START = 25'h000_0100;
    localparam ioctl_addr_t BA2_START = 25'h000_0200;

    // 96 MHz enable counter
    localparam int CEN_PERIOD = 24;
    localparam int CEN_W      = $clog2(CEN_PERIOD);

    // Counter steps between pulses: 16, 8 and 12 MHz
    localparam int PXL2_DIV = 6;
    localparam int PXL_DIV  = 12;
    localparam int CPU_DIV  = 8;

    typedef logic [CEN_W-1:0] cen_cnt_t;

    // ROM slot request sequence
    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_REQ,
        SLOT_WAIT,
        SLOT_DONE
    } slot_state_t;

endpackage

// File: game_cen.sv
`timescale 1ns/1ps

module game_cen import game_pkg::*; (
    input  logic clk,       // 96 MHz
    input  logic arst_n,
    output logic pxl2_cen,  // 16 MHz
    output logic pxl_cen,   //  8 MHz
    output logic cpu_cen    // 12 MHz
);

    cen_cnt_t cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (cnt == cen_cnt_t'(CEN_PERIOD - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Decode of the current count is registered, so count 0 right after
    // reset gives all three pulses on the first cycle out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
            cpu_cen  <= 1'b0;
        end else begin
            pxl2_cen <= (cnt % PXL2_DIV) == 0;
            pxl_cen  <= (cnt % PXL_DIV) == 0;
            cpu_cen  <= (cnt % CPU_DIV) == 0;
        end
    end

    // Pixel enable must stay aligned to the double rate one
    a_pxl_in_pxl2: assert property (
        @(posedge clk) disable iff (!arst_n)
        pxl_cen |-> pxl2_cen
    ) else $error("pxl_cen without pxl2_cen");

endmodule

// File: game_prog.sv
`timescale 1ns/1ps

module game_prog import game_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    input  logic        ba0_rdy,
    output logic        dwnld_busy,
    output sdram_addr_t prog_addr,
    output word_t       prog_data,
    output logic [ 1:0] prog_mask,
    output bank_t       prog_ba,
    output logic        prog_we,
    output logic        ba0_wr,
    output sdram_addr_t ba0_addr,
    output word_t       ba0_din
);

    logic        even_wr;
    logic        odd_wr;
    logic        have_even;
    logic [ 7:0] even_byte;
    bank_t       map_ba;
    ioctl_addr_t map_offset;

    assign even_wr = downloading && ioctl_wr && !ioctl_addr[0];
    assign odd_wr  = downloading && ioctl_wr &&  ioctl_addr[0];

    // Region lookup on the incoming byte address
    always_comb begin
        if (ioctl_addr < BA1_START) begin
            map_ba     = 2'd0;
            map_offset = ioctl_addr;
        end else if (ioctl_addr < BA2_START) begin
            map_ba     = 2'd1;
            map_offset = ioctl_addr - BA1_START;
        end else begin
            map_ba     = 2'd2;
            map_offset = ioctl_addr - BA2_START;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dwnld_busy <= 1'b0;
            prog_we    <= 1'b0;
            ba0_wr     <= 1'b0;
            have_even  <= 1'b0;
        end else begin
            dwnld_busy <= downloading;
            prog_we    <= odd_wr;
            if (even_wr) begin
                have_even <= 1'b1;
            end else if (odd_wr || !downloading) begin
                have_even <= 1'b0;
            end
            // Write request stays up until the bank reports it done
            if (odd_wr) begin
                ba0_wr <= 1'b1;
            end else if (ba0_rdy) begin
                ba0_wr <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (even_wr) begin
            even_byte <= ioctl_data;
        end
        if (odd_wr) begin
            prog_data <= {ioctl_data, have_even ? even_byte : 8'h00};
            prog_addr <= map_offset[22:1];
            prog_ba   <= map_ba;
        end
    end

    // Whole words only
    assign prog_mask = 2'b00;
    assign ba0_addr  = prog_addr;
    assign ba0_din   = prog_data;

    // A new word must not overwrite one the bank has not taken yet
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!arst_n)
        prog_we |-> !($past(ba0_wr) && !$past(ba0_rdy))
    ) else $error("prog_we while ba0_wr still pending");

endmodule

// File: game_rom_slot.sv
`timescale 1ns/1ps

module game_rom_slot import game_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        dwnld_busy,
    input  logic        cs,
    input  sdram_addr_t addr,
    output word_t       data,
    output logic        ok,
    output sdram_addr_t ba_addr,
    output logic        ba_rd,
    input  logic        ba_ack,
    input  logic        ba_rdy,
    input  word_t       data_read
);

    slot_state_t state;
    logic        rd_req;
    logic        cache_valid;
    sdram_addr_t cache_addr;
    word_t       cache_data;
    logic        hit;
    logic        accept;
    logic        start_rd;
    logic        capture;
    logic        serve;

    always_comb begin
        hit      = cs && cache_valid && (addr == cache_addr);
        accept   = (state == SLOT_IDLE) || (state == SLOT_DONE);
        start_rd = accept && cs && !dwnld_busy && !hit;
        capture  = (state == SLOT_WAIT) && ba_rdy;
        // Requester still wants the word that is arriving
        serve    = cs && (addr == ba_addr) && !dwnld_busy;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= SLOT_IDLE;
            rd_req      <= 1'b0;
            ok          <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            case (state)
                SLOT_IDLE, SLOT_DONE: begin
                    if (!cs || dwnld_busy) begin
                        ok    <= 1'b0;
                        state <= SLOT_IDLE;
                    end else if (hit) begin
                        ok    <= 1'b1;
                        state <= SLOT_DONE;
                    end else begin
                        ok     <= 1'b0;
                        rd_req <= 1'b1;
                        state  <= SLOT_REQ;
                    end
                end
                SLOT_REQ: begin
                    // Download takes the bank, drop the request
                    if (dwnld_busy) begin
                        rd_req <= 1'b0;
                        state  <= SLOT_IDLE;
                    end else if (ba_ack) begin
                        rd_req <= 1'b0;
                        state  <= SLOT_WAIT;
                    end
                end
                SLOT_WAIT: begin
                    if (ba_rdy) begin
                        cache_valid <= 1'b1;
                        ok          <= serve;
                        state       <= serve ? SLOT_DONE : SLOT_IDLE;
                    end
                end
                default: begin
                    state <= SLOT_IDLE;
                end
            endcase
            // ROM contents are being replaced
            if (dwnld_busy) begin
                cache_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_rd) begin
            ba_addr <= addr;
        end
        if (capture) begin
            cache_addr <= ba_addr;
            cache_data <= data_read;
        end
    end

    assign data  = cache_data;
    assign ba_rd = rd_req && !dwnld_busy;

    // A read in flight is abandoned the cycle after a download begins
    a_rd_drops_on_dwnld: assert property (
        @(posedge clk) disable iff (!arst_n)
        dwnld_busy |=> !rd_req
    ) else $error("bank read still requested during download");

    a_ok_needs_cs: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(ok) |-> $past(cs)
    ) else $error("ok rose without cs");

endmodule

// File: game_top.sv
`timescale 1ns/1ps

module game_top import game_pkg::*; (
    input  logic        clk,        // 96 MHz
    input  logic        arst_n,
    output logic        pxl2_cen,
    output logic        pxl_cen,
    output logic        cpu_cen,
    // ROM download
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    output sdram_addr_t prog_addr,
    output word_t       prog_data,
    output logic [ 1:0] prog_mask,
    output bank_t       prog_ba,
    output logic        prog_we,
    output logic        dwnld_busy,
    // Bank 0, write only here
    output logic        ba0_wr,
    output sdram_addr_t ba0_addr,
    output word_t       ba0_din,
    input  logic        ba0_rdy,
    // Main CPU ROM client
    input  logic        main_rom_cs,
    input  sdram_addr_t main_rom_addr,
    output word_t       main_rom_data,
    output logic        main_rom_ok,
    // Graphics ROM client
    input  logic        gfx_rom_cs,
    input  sdram_addr_t gfx_rom_addr,
    output word_t       gfx_rom_data,
    output logic        gfx_rom_ok,
    // Bank 1 read
    output sdram_addr_t ba1_addr,
    output logic        ba1_rd,
    input  logic        ba1_ack,
    input  logic        ba1_rdy,
    // Bank 2 read
    output sdram_addr_t ba2_addr,
    output logic        ba2_rd,
    input  logic        ba2_ack,
    input  logic        ba2_rdy,
    input  word_t       data_read
);

    game_cen u_cen (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .pxl2_cen   ( pxl2_cen      ),
        .pxl_cen    ( pxl_cen       ),
        .cpu_cen    ( cpu_cen       )
    );

    game_prog u_prog (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .downloading( downloading   ),
        .ioctl_addr ( ioctl_addr    ),
        .ioctl_data ( ioctl_data    ),
        .ioctl_wr   ( ioctl_wr      ),
        .ba0_rdy    ( ba0_rdy       ),
        .dwnld_busy ( dwnld_busy    ),
        .prog_addr  ( prog_addr     ),
        .prog_data  ( prog_data     ),
        .prog_mask  ( prog_mask     ),
        .prog_ba    ( prog_ba       ),
        .prog_we    ( prog_we       ),
        .ba0_wr     ( ba0_wr        ),
        .ba0_addr   ( ba0_addr      ),
        .ba0_din    ( ba0_din       )
    );

    // Main CPU code sits in bank 1
    game_rom_slot u_main_rom (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .dwnld_busy ( dwnld_busy    ),
        .cs         ( main_rom_cs   ),
        .addr       ( main_rom_addr ),
        .data       ( main_rom_data ),
        .ok         ( main_rom_ok   ),
        .ba_addr    ( ba1_addr      ),
        .ba_rd      ( ba1_rd        ),
        .ba_ack     ( ba1_ack       ),
        .ba_rdy     ( ba1_rdy       ),
        .data_read  ( data_read     )
    );

    // Tiles and sprites in bank 2
    game_rom_slot u_gfx_rom (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .dwnld_busy ( dwnld_busy    ),
        .cs         ( gfx_rom_cs    ),
        .addr       ( gfx_rom_addr  ),
        .data       ( gfx_rom_data  ),
        .ok         ( gfx_rom_ok    ),
        .ba_addr    ( ba2_addr      ),
        .ba_rd      ( ba2_rd        ),
        .ba_ack     ( ba2_ack       ),
        .ba_rdy     ( ba2_rdy       ),
        .data_read  ( data_read     )
    );

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker import game_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pxl2_cen,
    input  logic        pxl_cen,
    input  logic        cpu_cen,
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    input  logic        dwnld_busy,
    input  logic        prog_we,
    input  sdram_addr_t prog_addr,
    input  word_t       prog_data,
    input  logic [ 1:0] prog_mask,
    input  bank_t       prog_ba,
    input  logic        ba0_wr,
    input  logic        main_rom_cs,
    input  logic        main_rom_ok,
    input  word_t       main_rom_data,
    input  logic        gfx_rom_cs,
    input  logic        gfx_rom_ok,
    input  word_t       gfx_rom_data,
    input  logic        ba1_rd,
    input  logic        ba2_rd,
    // Read result to compare, raised by the stimulus for one cycle
    input  logic        chk_req,
    input  logic        chk_slot,
    input  logic        chk_hit,
    input  sdram_addr_t chk_addr,
    input  word_t       chk_word
);

    int          val_errs = 0;
    int          cen_errs = 0;
    int          proto_errs = 0;
    int          cyc = 0;
    int          last_pulse [3] = '{-1, -1, -1};
    int          pulse_cnt [3] = '{0, 0, 0};
    int          rises [2] = '{0, 0};
    logic        prev_rd [2] = '{1'b0, 1'b0};
    logic        prev_dl = 1'b0;
    logic [ 7:0] held_even;
    logic        have_even = 1'b0;
    logic        exp_we = 1'b0;
    word_t       exp_data;
    bank_t       exp_ba;
    sdram_addr_t exp_addr;
    word_t       dl_mem [int];

    // Spacing between pulses and pulse count per 24-cycle window
    task automatic check_enable(input int idx, input logic pulse, input int period,
                                input int per_window, input string name);
        if (pulse) begin
            if (last_pulse[idx] >= 0 && cyc - last_pulse[idx] != period) begin
                $display("[ERROR] %0t: %s spacing %0d, expected %0d", $time, name,
                         cyc - last_pulse[idx], period);
                cen_errs++;
            end
            last_pulse[idx] = cyc;
            pulse_cnt[idx]++;
        end
        if (cyc % 24 == 23) begin
            if (pulse_cnt[idx] != per_window) begin
                $display("[ERROR] %0t: %s pulsed %0d times in 24 cycles, expected %0d",
                         $time, name, pulse_cnt[idx], per_window);
                cen_errs++;
            end
            pulse_cnt[idx] = 0;
        end
    endtask

    always @(negedge clk) begin
        ioctl_addr_t off;
        logic        ok_v;
        word_t       d_v;
        int          key;
        if (!arst_n) begin
            if (ba1_rd || ba2_rd || main_rom_ok || gfx_rom_ok || prog_we || ba0_wr) begin
                $display("[ERROR] %0t: output active during reset", $time);
                val_errs++;
            end
        end else begin
            check_enable(0, pxl2_cen, 6, 4, "pxl2_cen");
            check_enable(1, pxl_cen, 12, 2, "pxl_cen");
            check_enable(2, cpu_cen, 8, 3, "cpu_cen");
            cyc++;

            // Busy flag trails downloading by one cycle
            if (dwnld_busy !== prev_dl) begin
                $display("[ERROR] %0t: dwnld_busy %b, expected %b", $time,
                         dwnld_busy, prev_dl);
                val_errs++;
            end
            prev_dl = downloading;

            // Packed word from the byte pair seen one cycle earlier
            if (exp_we) begin
                if (!prog_we || prog_data !== exp_data || prog_ba !== exp_ba ||
                    prog_addr !== exp_addr || prog_mask !== 2'b00) begin
                    $display("[ERROR] %0t: prog write %0d/%h/%h, expected %0d/%h/%h",
                             $time, prog_ba, prog_addr, prog_data, exp_ba, exp_addr, exp_data);
                    val_errs++;
                end
            end else if (prog_we) begin
                $display("[ERROR] %0t: unexpected prog_we", $time);
                val_errs++;
            end
            exp_we = 1'b0;
            if (!downloading) begin
                have_even = 1'b0;
            end else if (ioctl_wr && !ioctl_addr[0]) begin
                held_even = ioctl_data;
                have_even = 1'b1;
            end else if (ioctl_wr) begin
                if (ioctl_addr < BA1_START) begin
                    exp_ba = 2'd0;
                    off    = ioctl_addr;
                end else if (ioctl_addr < BA2_START) begin
                    exp_ba = 2'd1;
                    off    = ioctl_addr - BA1_START;
                end else begin
                    exp_ba = 2'd2;
                    off    = ioctl_addr - BA2_START;
                end
                exp_addr  = sdram_addr_t'(off >> 1);
                exp_data  = {ioctl_data, have_even ? held_even : 8'h00};
                have_even = 1'b0;
                exp_we    = 1'b1;
                dl_mem[exp_ba * (1 << 22) + exp_addr] = exp_data;
            end

            if (downloading && (main_rom_cs || gfx_rom_cs) && (ba1_rd || ba2_rd)) begin
                $display("[ERROR] %0t: bank read issued during download", $time);
                proto_errs++;
            end
            if (ba1_rd && !prev_rd[0]) rises[0]++;
            if (ba2_rd && !prev_rd[1]) rises[1]++;
            prev_rd[0] = ba1_rd;
            prev_rd[1] = ba2_rd;

            if (chk_req) begin
                ok_v = chk_slot ? gfx_rom_ok : main_rom_ok;
                d_v  = chk_slot ? gfx_rom_data : main_rom_data;
                key  = (chk_slot ? 2 : 1) * (1 << 22) + int'(chk_addr);
                if (!ok_v || d_v !== chk_word) begin
                    $display("[ERROR] %0t: slot %0d read %h ok %b, expected %h", $time,
                             chk_slot, d_v, ok_v, chk_word);
                    val_errs++;
                end
                if (!dl_mem.exists(key) || dl_mem[key] !== chk_word) begin
                    $display("[ERROR] %0t: expected word %h is not the downloaded word",
                             $time, chk_word);
                    val_errs++;
                end
                if (rises[chk_slot] != (chk_hit ? 0 : 1)) begin
                    $display("[ERROR] %0t: slot %0d issued %0d bank reads, expected %0d",
                             $time, chk_slot, rises[chk_slot], chk_hit ? 0 : 1);
                    proto_errs++;
                end
                rises[chk_slot] = 0;
            end
        end
    end

endmodule

// File: tb_game.sv
`timescale 1ns/1ps

module tb_game import game_pkg::*;;

    localparam int WAIT_LIMIT = 500;

    logic        clk;
    logic        arst_n;
    logic        pxl2_cen;
    logic        pxl_cen;
    logic        cpu_cen;
    logic        downloading;
    ioctl_addr_t ioctl_addr;
    logic [ 7:0] ioctl_data;
    logic        ioctl_wr;
    sdram_addr_t prog_addr;
    word_t       prog_data;
    logic [ 1:0] prog_mask;
    bank_t       prog_ba;
    logic        prog_we;
    logic        dwnld_busy;
    logic        ba0_wr;
    logic        ba0_rdy;
    sdram_addr_t ba0_addr;
    word_t       ba0_din;
    logic        main_rom_cs;
    logic        main_rom_ok;
    logic        gfx_rom_cs;
    logic        gfx_rom_ok;
    sdram_addr_t main_rom_addr;
    sdram_addr_t gfx_rom_addr;
    word_t       main_rom_data;
    word_t       gfx_rom_data;
    sdram_addr_t ba1_addr;
    sdram_addr_t ba2_addr;
    logic        ba1_rd;
    logic        ba1_ack;
    logic        ba1_rdy;
    logic        ba2_rd;
    logic        ba2_ack;
    logic        ba2_rdy;
    word_t       data_read;
    logic        chk_req;
    logic        chk_slot;
    logic        chk_hit;
    sdram_addr_t chk_addr;
    word_t       chk_word;

    word_t       mem [0:2][0:255];
    logic [31:0] rng = 32'd68;
    int          other_errs = 0;
    int          last_addr [2] = '{-1, -1};

    game_top dut_i (.*);

    tb_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int next_delay();
        rng = xorshift32(rng);
        return 1 + int'(rng % 4);
    endfunction

    task automatic give_up(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic set_strobes(input int bank, input logic ack, input logic rdy);
        if (bank == 1) begin
            ba1_ack = ack;
            ba1_rdy = rdy;
        end else begin
            ba2_ack = ack;
            ba2_rdy = rdy;
        end
    endtask

    // Bank model, ack after a random delay, then rdy with the word
    task automatic answer_read(input int bank);
        sdram_addr_t a;
        int          d;
        a = (bank == 1) ? ba1_addr : ba2_addr;
        d = next_delay();
        repeat (d) @(posedge clk);
        #1;
        set_strobes(bank, 1'b1, 1'b0);
        @(posedge clk);
        #1;
        set_strobes(bank, 1'b0, 1'b0);
        d = next_delay();
        repeat (d) @(posedge clk);
        #1;
        data_read = mem[bank][a[7:0]];
        set_strobes(bank, 1'b0, 1'b1);
        @(posedge clk);
        #1;
        set_strobes(bank, 1'b0, 1'b0);
    endtask

    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (ba1_rd) answer_read(1);
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (ba2_rd) answer_read(2);
        end
    end

    // Download writes land in the bank chosen by prog_ba
    initial begin
        int d;
        forever begin
            @(posedge clk);
            #1;
            if (ba0_wr) begin
                d = next_delay();
                repeat (d) @(posedge clk);
                #1;
                mem[prog_ba][ba0_addr[7:0]] = ba0_din;
                ba0_rdy = 1'b1;
                @(posedge clk);
                #1;
                ba0_rdy = 1'b0;
            end
        end
    end

    task automatic write_byte(input ioctl_addr_t a, input logic [7:0] d);
        int n;
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
        n = 0;
        while (a[0] && ba0_wr) begin
            n++;
            if (n > WAIT_LIMIT) give_up("the bank 0 write to finish");
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_download();
        int n;
        main_rom_cs = 1'b0;
        gfx_rom_cs  = 1'b0;
        @(posedge clk);
        #1;
        downloading = 1'b0;
        n = 0;
        while (dwnld_busy || ba0_wr) begin
            n++;
            if (n > WAIT_LIMIT) give_up("the download to end");
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_rom(input int slot, input sdram_addr_t a, input word_t w);
        int n;
        chk_hit = (last_addr[slot] == int'(a));
        last_addr[slot] = int'(a);
        if (slot == 1) begin
            gfx_rom_addr = a;
            gfx_rom_cs   = 1'b1;
        end else begin
            main_rom_addr = a;
            main_rom_cs   = 1'b1;
        end
        n = 0;
        do begin
            n++;
            if (n > WAIT_LIMIT) give_up("a ROM slot ok");
            @(posedge clk);
            #1;
        end while (!(slot == 1 ? gfx_rom_ok : main_rom_ok));
        chk_slot = (slot == 1);
        chk_addr = a;
        chk_word = w;
        chk_req  = 1'b1;
        @(posedge clk);
        #1;
        chk_req     = 1'b0;
        main_rom_cs = 1'b0;
        gfx_rom_cs  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic run_vectors(input int fd);
        int    r;
        int    slot;
        int    a;
        int    d;
        string kind;
        string line;
        while (!$feof(fd)) begin
            r = $fscanf(fd, " %s", kind);
            if (r != 1) break;
            if (kind == "#") begin
                r = $fgets(line, fd);
            end else if (kind == "D") begin
                r = $fscanf(fd, " %h %h", a, d);
                write_byte(ioctl_addr_t'(a), d[7:0]);
            end else if (kind == "R") begin
                if (downloading) finish_download();
                r = $fscanf(fd, " %d %h %h", slot, a, d);
                read_rom(slot, sdram_addr_t'(a), word_t'(d));
            end else begin
                $display("Unknown line kind %s in the vector file", kind);
                other_errs++;
            end
        end
    endtask

    initial begin
        int fd;
        for (int b = 0; b < 3; b++) begin
            for (int i = 0; i < 256; i++) begin
                mem[b][i] = 16'hE000 ^ word_t'(b * 256 + i);
            end
        end
        arst_n = 1'b0;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        ioctl_wr = 1'b0;
        ba0_rdy = 1'b0;
        main_rom_cs = 1'b0;
        main_rom_addr = '0;
        gfx_rom_cs = 1'b0;
        gfx_rom_addr = '0;
        ba1_ack = 1'b0;
        ba1_rdy = 1'b0;
        ba2_ack = 1'b0;
        ba2_rdy = 1'b0;
        data_read = '0;
        chk_req = 1'b0;
        chk_slot = 1'b0;
        chk_hit = 1'b0;
        chk_addr = '0;
        chk_word = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (30) @(posedge clk);
        #1;
        // Slots keep requesting while the download runs
        downloading   = 1'b1;
        main_rom_cs   = 1'b1;
        main_rom_addr = 22'd5;
        gfx_rom_cs    = 1'b1;
        gfx_rom_addr  = 22'd3;
        fd = $fopen("game_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open game_vectors.txt");
            other_errs++;
        end else begin
            run_vectors(fd);
            $fclose(fd);
        end
        repeat (30) @(posedge clk);
        $display("Errors: value %0d, enable %0d, protocol %0d, other %0d",
                 u_checker.val_errs, u_checker.cen_errs, u_checker.proto_errs, other_errs);
        if (u_checker.val_errs + u_checker.cen_errs + u_checker.proto_errs +
            other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: game_vectors.txt
# D byte_addr data_byte                 (hex, download)
# R slot(0 main,1 gfx) word_addr expect (hex word, after download)
D 000 11
D 001 22
D 002 33
D 003 44
D 100 a1
D 101 b1
D 102 a2
D 103 b2
D 104 a3
D 105 b3
D 106 a4
D 107 b4
D 200 c1
D 201 d1
D 202 c2
D 203 d2
D 204 c3
D 205 d3
R 0 000000 b1a1
R 0 000000 b1a1
R 0 000002 b3a3
R 1 000001 d2c2
R 1 000001 d2c2
R 1 000002 d3c3
R 0 000003 b4a4
R 0 000001 b2a2
R 1 000000 d1c1

// File: sources.f
game_pkg.sv
game_cen.sv
game_prog.sv
game_rom_slot.sv
game_top.sv
tb_checker.sv
tb_game.sv
